// File: all.f
+incdir+include
src/kernel_pkg.sv
src/kernel_if.sv
src/kernel_reset_hold.sv
src/kernel_control.sv
src/kernel_beat_counter.sv
src/kernel_read_engine.sv
src/kernel_write_engine.sv
src/kernel_line_buffer.sv
src/kernel_afu.sv
sim/kernel_afu_assert.sv
sim/tb_kernel_afu.sv

// File: include/kernel_settings.svh
/* Memory copy kernel build settings
   Widths, burst limit and reset hold length */

`ifndef KERNEL_SETTINGS_SVH
`define KERNEL_SETTINGS_SVH

// ----------------------------------------
// Data path
// ----------------------------------------
`define KERNEL_DATA_W     64  // One AXI beat
`define KERNEL_ADDR_W     64  // Byte address

// ----------------------------------------
// Burst shape
// ----------------------------------------
`define KERNEL_LEN_W      8   // AXI4 arlen / awlen field
`define KERNEL_MAX_BEATS  16  // Line buffer depth, also the burst cap

// ----------------------------------------
// Reset
// ----------------------------------------
// Cycles areset_kernel stays high once ap_rst_n is released
`define KERNEL_RESET_HOLD 16

`endif

// File: run.sh
#!/usr/bin/env bash
# Build and run the memory copy kernel testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_kernel_afu -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_kernel_afu +verilator+error+limit+100)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// File: sim/kernel_afu_assert.sv
/* Bound assertions for the memory copy kernel
   AXI valid stability and the ap_ready pulse */

`default_nettype none

module kernel_afu_assert (
  input logic              ap_clk,
  input logic              ap_rst_n,
  input logic              ap_start,
  input logic              ap_idle,
  input logic              ap_ready,
  input logic              m00_axi_arvalid,
  input logic              m00_axi_arready,
  input kernel_pkg::addr_t m00_axi_araddr,
  input kernel_pkg::len_t  m00_axi_arlen,
  input logic              m00_axi_wvalid,
  input logic              m00_axi_wready,
  input kernel_pkg::data_t m00_axi_wdata,
  input logic              m00_axi_wlast
);

  int fail_count = 0;  // Failed assertions so far

  // ----------------------------------------
  // AXI valid and payload hold
  // ----------------------------------------
  ar_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
      m00_axi_arvalid && !m00_axi_arready |=>
      m00_axi_arvalid && $stable(m00_axi_araddr) && $stable(m00_axi_arlen))
    else begin
      $error("arvalid or araddr changed before arready");
      fail_count++;
    end

  w_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
      m00_axi_wvalid && !m00_axi_wready |=>
      m00_axi_wvalid && $stable(m00_axi_wdata) && $stable(m00_axi_wlast))
    else begin
      $error("wvalid or wdata changed before wready");
      fail_count++;
    end

  // ----------------------------------------
  // Control chain
  // ----------------------------------------
  // ap_ready only right after a start sampled while idle
  ready_pulse: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
      ap_ready |-> $past(ap_start && ap_idle))
    else begin
      $error("ap_ready high without a start accepted the cycle before");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: sim/tb_kernel_afu.sv
/* Testbench for the memory copy kernel
   AXI memory model with random stalls, directed copy and control chain tests */

`default_nettype none

`include "kernel_settings.svh"

module tb_kernel_afu;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 8;
  localparam int RUN_LIMIT       = 200;  // Longest expected start to ap_done
  localparam int RUN_OVERHEAD    = 20;   // Start, continue and checks around one run
  localparam int NUM_RUNS        = 7;
  localparam int MEM_WORDS       = 256;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + `KERNEL_RESET_HOLD + 2
                                   + NUM_RUNS * (RUN_LIMIT + RUN_OVERHEAD);
  localparam logic [31:0] SEED   = 32'h2adafb97;

  // ----------------------------------------
  // DUT ports
  // ----------------------------------------
  logic              ap_clk;
  logic              ap_rst_n;
  logic              ap_start;
  logic              ap_idle;
  logic              ap_ready;
  logic              ap_done;
  logic              ap_continue;
  kernel_pkg::addr_t buffer_0;
  kernel_pkg::addr_t buffer_1;
  kernel_pkg::addr_t buffer_2;
  logic              m00_axi_arvalid;
  logic              m00_axi_arready = 1'b0;
  kernel_pkg::addr_t m00_axi_araddr;
  kernel_pkg::len_t  m00_axi_arlen;
  logic              m00_axi_rvalid  = 1'b0;
  logic              m00_axi_rready;
  kernel_pkg::data_t m00_axi_rdata   = '0;
  logic              m00_axi_rlast   = 1'b0;
  logic              m00_axi_awvalid;
  logic              m00_axi_awready = 1'b0;
  kernel_pkg::addr_t m00_axi_awaddr;
  kernel_pkg::len_t  m00_axi_awlen;
  logic              m00_axi_wvalid;
  logic              m00_axi_wready  = 1'b0;
  kernel_pkg::data_t m00_axi_wdata;
  logic              m00_axi_wlast;
  logic              m00_axi_bvalid  = 1'b0;
  logic              m00_axi_bready;

  // Memory model state
  logic [63:0] mem [MEM_WORDS];
  logic [7:0]  rd_ptr;
  logic [7:0]  rd_left;    // Beats after the current one
  logic        rd_busy;
  logic [7:0]  wr_ptr;
  logic [7:0]  wr_len;
  logic [7:0]  wr_beat;
  logic        resp_due;   // Response owed after the last beat
  logic        stall_en;
  logic [31:0] rng;

  // Transaction log for the running test
  int                ar_count;
  int                aw_count;
  int                w_count;
  int                b_count;
  kernel_pkg::addr_t ar_addr_seen;
  kernel_pkg::addr_t aw_addr_seen;
  kernel_pkg::len_t  ar_len_seen;
  kernel_pkg::len_t  aw_len_seen;

  int checks;
  int errors;
  int tests;

  kernel_afu u_dut (.*);

  bind kernel_afu kernel_afu_assert u_assert (
    .ap_clk          (ap_clk),
    .ap_rst_n        (ap_rst_n),
    .ap_start        (ap_start),
    .ap_idle         (ap_idle),
    .ap_ready        (ap_ready),
    .m00_axi_arvalid (m00_axi_arvalid),
    .m00_axi_arready (m00_axi_arready),
    .m00_axi_araddr  (m00_axi_araddr),
    .m00_axi_arlen   (m00_axi_arlen),
    .m00_axi_wvalid  (m00_axi_wvalid),
    .m00_axi_wready  (m00_axi_wready),
    .m00_axi_wdata   (m00_axi_wdata),
    .m00_axi_wlast   (m00_axi_wlast)
  );

  initial begin
    ap_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Source pattern folding in every address bit
  function automatic logic [63:0] fill_word(input logic [63:0] addr);
    logic [31:0] folded;
    folded = addr[63:32] ^ addr[31:0];
    return {folded ^ 32'hc3a5_1e6d, (folded * 32'h9e37_79b1) ^ 32'h0f1e_2d3c};
  endfunction

  function automatic logic [63:0] poison_word(input logic [63:0] addr);
    return fill_word(addr) ^ 64'hffff_0000_ffff_0000;
  endfunction

  function automatic logic [63:0] reverse_bytes(input logic [63:0] w);
    logic [63:0] r;
    r = {<<8{w}};
    return r;
  endfunction

  function automatic logic [7:0] word_idx(input logic [63:0] addr);
    return addr[10:3];  // 2 KiB model of 8-byte words
  endfunction

  function automatic int error_total();
    return errors + u_dut.u_assert.fail_count;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests++;
    $display("Test %s finished with %0d errors", name, error_total() - err_start);
  endtask

  // ----------------------------------------
  // AXI memory model with one burst per channel
  // ----------------------------------------
  always @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      rd_busy  = 1'b0;
      rd_ptr   = '0;
      rd_left  = '0;
      wr_ptr   = '0;
      wr_len   = '0;
      wr_beat  = '0;
      resp_due = 1'b0;
      m00_axi_arready <= 1'b0;
      m00_axi_rvalid  <= 1'b0;
      m00_axi_rlast   <= 1'b0;
      m00_axi_awready <= 1'b0;
      m00_axi_wready  <= 1'b0;
      m00_axi_bvalid  <= 1'b0;
    end else begin
      rng = next_random(rng);
      if (m00_axi_arvalid && m00_axi_arready) begin
        rd_ptr       = word_idx(m00_axi_araddr);
        rd_left      = m00_axi_arlen;
        rd_busy      = 1'b1;
        ar_count     = ar_count + 1;
        ar_addr_seen = m00_axi_araddr;
        ar_len_seen  = m00_axi_arlen;
      end
      if (m00_axi_rvalid && m00_axi_rready) begin
        if (m00_axi_rlast) begin
          rd_busy = 1'b0;
        end else begin
          rd_ptr  = rd_ptr + 8'd1;
          rd_left = rd_left - 8'd1;
        end
      end
      if (m00_axi_awvalid && m00_axi_awready) begin
        wr_ptr       = word_idx(m00_axi_awaddr);
        wr_len       = m00_axi_awlen;
        wr_beat      = '0;
        aw_count     = aw_count + 1;
        aw_addr_seen = m00_axi_awaddr;
        aw_len_seen  = m00_axi_awlen;
      end
      if (m00_axi_wvalid && m00_axi_wready) begin
        mem[wr_ptr] = m00_axi_wdata;
        check_value("m00_axi_wlast", 64'(m00_axi_wlast), 64'(wr_beat == wr_len));
        if (m00_axi_wlast) resp_due = 1'b1;
        wr_ptr  = wr_ptr + 8'd1;
        wr_beat = wr_beat + 8'd1;
        w_count = w_count + 1;
      end
      if (m00_axi_bvalid && m00_axi_bready) begin
        resp_due = 1'b0;
        b_count  = b_count + 1;
      end
      m00_axi_arready <= !stall_en || rng[2];
      m00_axi_awready <= !stall_en || rng[5];
      m00_axi_wready  <= !stall_en || (rng[9:8] != 2'b00);  // Three in four
      m00_axi_rvalid  <= rd_busy;
      m00_axi_rdata   <= mem[rd_ptr];
      m00_axi_rlast   <= rd_busy && (rd_left == 8'd0);
      // Late response under stalls and held once raised
      m00_axi_bvalid  <= resp_due && (m00_axi_bvalid || !stall_en || (rng[13:12] == 2'b00));
    end
  end

  // ----------------------------------------
  // One full run through the control chain
  // ----------------------------------------
  task automatic run_copy(input kernel_pkg::addr_t src, input kernel_pkg::addr_t dst,
                          input kernel_pkg::len_t len_m1, input logic endian_rd,
                          input logic endian_wr, input logic stalls);
    logic [63:0] expected;
    logic [63:0] addr;
    stall_en <= stalls;
    for (int i = 0; i <= int'(len_m1) + 1; i++) begin
      addr = dst + 64'(8 * i);
      mem[word_idx(addr)] = poison_word(addr);  // Stale data must not pass
    end
    ar_count = 0;
    aw_count = 0;
    w_count  = 0;
    b_count  = 0;

    @(posedge ap_clk);
    buffer_0 <= src;
    buffer_1 <= dst;
    buffer_2 <= 64'({endian_wr, endian_rd, len_m1});
    ap_start <= 1'b1;
    @(posedge ap_clk);  // Start sampled
    ap_start <= 1'b0;
    buffer_0 <= ~src;   // Descriptor already latched
    buffer_1 <= ~dst;
    buffer_2 <= 64'({~endian_wr, ~endian_rd, ~len_m1});
    @(posedge ap_clk);
    check_value("ap_ready", 64'(ap_ready), 64'd1);
    check_value("ap_idle", 64'(ap_idle), 64'd0);
    @(posedge ap_clk);
    check_value("ap_ready", 64'(ap_ready), 64'd0);
    check_value("m00_axi_arvalid", 64'(m00_axi_arvalid), 64'd1);  // One cycle after ap_ready

    // The watchdog ends a run that never reaches ap_done
    while (!ap_done) begin
      @(posedge ap_clk);
      check_value("ap_ready", 64'(ap_ready), 64'd0);
    end

    // ap_done holds until the host continues
    repeat (4) begin
      @(posedge ap_clk);
      check_value("ap_done", 64'(ap_done), 64'd1);
      check_value("ap_idle", 64'(ap_idle), 64'd0);
    end
    ap_continue <= 1'b1;
    @(posedge ap_clk);  // Continue sampled
    ap_continue <= 1'b0;
    check_value("ap_done", 64'(ap_done), 64'd1);
    @(posedge ap_clk);
    check_value("ap_done", 64'(ap_done), 64'd0);
    check_value("ap_idle", 64'(ap_idle), 64'd1);

    check_value("ar handshakes", 64'(ar_count), 64'd1);
    check_value("aw handshakes", 64'(aw_count), 64'd1);
    check_value("m00_axi_araddr", ar_addr_seen, src);
    check_value("m00_axi_awaddr", aw_addr_seen, dst);
    check_value("m00_axi_arlen", 64'(ar_len_seen), 64'(len_m1));
    check_value("m00_axi_awlen", 64'(aw_len_seen), 64'(len_m1));
    check_value("w beats", 64'(w_count), 64'(len_m1) + 64'd1);
    check_value("b handshakes", 64'(b_count), 64'd1);
    for (int i = 0; i <= int'(len_m1); i++) begin
      expected = fill_word(src + 64'(8 * i));
      if (endian_rd != endian_wr) expected = reverse_bytes(expected);  // One swap only
      addr = dst + 64'(8 * i);
      check_value($sformatf("mem[%h]", addr), mem[word_idx(addr)], expected);
    end
    addr = dst + 64'(8 * (int'(len_m1) + 1));
    check_value($sformatf("mem[%h]", addr), mem[word_idx(addr)], poison_word(addr));
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_reset_values();
    int err_start;
    err_start = error_total();
    ap_start <= 1'b1;  // Held kernel must not take it
    for (int c = 0; c < `KERNEL_RESET_HOLD + 2; c++) begin
      @(posedge ap_clk);
      if (c == `KERNEL_RESET_HOLD - 3) ap_start <= 1'b0;  // Dropped before the hold ends
      check_value("ap_idle", 64'(ap_idle), 64'd1);
      check_value("ap_ready", 64'(ap_ready), 64'd0);
      check_value("ap_done", 64'(ap_done), 64'd0);
      check_value("m00_axi_arvalid", 64'(m00_axi_arvalid), 64'd0);
      check_value("m00_axi_awvalid", 64'(m00_axi_awvalid), 64'd0);
      check_value("m00_axi_wvalid", 64'(m00_axi_wvalid), 64'd0);
    end
    finish_test("reset values", err_start);
  endtask

  task automatic test_plain_copy();
    int err_start;
    err_start = error_total();
    run_copy(64'h100, 64'h400, 8'd3, 1'b0, 1'b0, 1'b0);
    finish_test("plain copy", err_start);
  endtask

  task automatic test_endian();
    int err_start;
    err_start = error_total();
    run_copy(64'h180, 64'h500, 8'd7, 1'b1, 1'b0, 1'b0);
    run_copy(64'h180, 64'h600, 8'd7, 1'b0, 1'b1, 1'b0);
    run_copy(64'h180, 64'h700, 8'd7, 1'b1, 1'b1, 1'b0);  // Swaps cancel
    finish_test("endian", err_start);
  endtask

  task automatic test_stalled_copy();
    int err_start;
    err_start = error_total();
    run_copy(64'h000, 64'h300, 8'd15, 1'b0, 1'b0, 1'b1);
    finish_test("stalled copy", err_start);
  endtask

  task automatic test_control_chain();
    int err_start;
    err_start = error_total();
    run_copy(64'h200, 64'h480, 8'd5, 1'b0, 1'b1, 1'b1);
    run_copy(64'h0a8, 64'h5c0, 8'd10, 1'b1, 1'b0, 1'b1);  // Second run with new ports
    finish_test("control chain", err_start);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int total_errors;
    ap_rst_n    = 1'b0;
    ap_start    = 1'b0;
    ap_continue = 1'b0;
    buffer_0    = '0;
    buffer_1    = '0;
    buffer_2    = '0;
    stall_en    = 1'b0;
    rng         = SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(64'(i) << 3);
    end
    repeat (RESET_CYCLES) @(posedge ap_clk);
    ap_rst_n <= 1'b1;

    test_reset_values();
    test_plain_copy();
    test_endian();
    test_stalled_copy();
    test_control_chain();

    total_errors = error_total();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, total_errors);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Backstop for a stuck run
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired at %0t, the tests did not complete", $time);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/kernel_afu.sv
/* Memory copy kernel top
   ap_ctrl_chain control with one AXI4 master, copies a burst buffer_0 to buffer_1 */

`default_nettype none

module kernel_afu (
  input  logic              ap_clk,
  input  logic              ap_rst_n,
  // Control chain
  input  logic              ap_start,
  output logic              ap_idle,
  output logic              ap_ready,
  output logic              ap_done,
  input  logic              ap_continue,
  input  kernel_pkg::addr_t buffer_0,  // Source
  input  kernel_pkg::addr_t buffer_1,  // Destination
  input  kernel_pkg::addr_t buffer_2,  // [7:0] len-1, [8] endian_read, [9] endian_write
  // AXI4 master, read
  output logic              m00_axi_arvalid,
  input  logic              m00_axi_arready,
  output kernel_pkg::addr_t m00_axi_araddr,
  output kernel_pkg::len_t  m00_axi_arlen,
  input  logic              m00_axi_rvalid,
  output logic              m00_axi_rready,
  input  kernel_pkg::data_t m00_axi_rdata,
  input  logic              m00_axi_rlast,
  // AXI4 master, write
  output logic              m00_axi_awvalid,
  input  logic              m00_axi_awready,
  output kernel_pkg::addr_t m00_axi_awaddr,
  output kernel_pkg::len_t  m00_axi_awlen,
  output logic              m00_axi_wvalid,
  input  logic              m00_axi_wready,
  output kernel_pkg::data_t m00_axi_wdata,
  output logic              m00_axi_wlast,
  input  logic              m00_axi_bvalid,
  output logic              m00_axi_bready
);

  logic areset_kernel;  // Stretched reset to all blocks

  kernel_phase_if  read_phase ();
  kernel_phase_if  write_phase ();
  kernel_buffer_if line_buf ();

  // ----------------------------------------
  // Reset and control
  // ----------------------------------------
  kernel_reset_hold u_reset_hold (
    .ap_clk        (ap_clk),
    .ap_rst_n      (ap_rst_n),
    .areset_kernel (areset_kernel)
  );

  kernel_control u_control (
    .ap_clk      (ap_clk),
    .areset      (areset_kernel),
    .ap_start    (ap_start),
    .ap_continue (ap_continue),
    .buffer_0    (buffer_0),
    .buffer_1    (buffer_1),
    .buffer_2    (buffer_2),
    .ap_idle     (ap_idle),
    .ap_ready    (ap_ready),
    .ap_done     (ap_done),
    .read_phase  (read_phase),
    .write_phase (write_phase)
  );

  // ----------------------------------------
  // Data path
  // ----------------------------------------
  kernel_read_engine u_read_engine (
    .ap_clk        (ap_clk),
    .areset        (areset_kernel),
    .phase         (read_phase),
    .buf_fill      (line_buf),
    .m_axi_arvalid (m00_axi_arvalid),
    .m_axi_arready (m00_axi_arready),
    .m_axi_araddr  (m00_axi_araddr),
    .m_axi_arlen   (m00_axi_arlen),
    .m_axi_rvalid  (m00_axi_rvalid),
    .m_axi_rready  (m00_axi_rready),
    .m_axi_rdata   (m00_axi_rdata),
    .m_axi_rlast   (m00_axi_rlast)
  );

  kernel_line_buffer u_line_buffer (
    .ap_clk    (ap_clk),
    .buf_store (line_buf)
  );

  kernel_write_engine u_write_engine (
    .ap_clk        (ap_clk),
    .areset        (areset_kernel),
    .phase         (write_phase),
    .buf_drain     (line_buf),
    .m_axi_awvalid (m00_axi_awvalid),
    .m_axi_awready (m00_axi_awready),
    .m_axi_awaddr  (m00_axi_awaddr),
    .m_axi_awlen   (m00_axi_awlen),
    .m_axi_wvalid  (m00_axi_wvalid),
    .m_axi_wready  (m00_axi_wready),
    .m_axi_wdata   (m00_axi_wdata),
    .m_axi_wlast   (m00_axi_wlast),
    .m_axi_bvalid  (m00_axi_bvalid),
    .m_axi_bready  (m00_axi_bready)
  );

endmodule

`default_nettype wire

// File: src/kernel_beat_counter.sv
/* Beat index counter with last beat flag, shared by both engines */

`default_nettype none

module kernel_beat_counter (
  input  logic                  ap_clk,
  input  logic                  areset,
  input  logic                  clear,    // New burst
  input  logic                  advance,  // Beat accepted
  input  kernel_pkg::len_t      len,      // Beats minus one
  output kernel_pkg::beat_idx_t idx,
  output logic                  last
);

  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      idx <= '0;
    end else if (clear) begin
      idx <= '0;
    end else if (advance) begin
      idx <= idx + 1'b1;
    end
  end

  assign last = (kernel_pkg::len_t'(idx) == len);  // Current slot is the final beat

endmodule

`default_nettype wire

// File: src/kernel_control.sv
/* ap_ctrl_chain controller
   Latches the descriptor and runs the read phase, then the write phase */

`default_nettype none

`include "kernel_settings.svh"

module kernel_control (
  input  logic              ap_clk,
  input  logic              areset,
  input  logic              ap_start,
  input  logic              ap_continue,
  input  kernel_pkg::addr_t buffer_0,     // Source
  input  kernel_pkg::addr_t buffer_1,     // Destination
  input  kernel_pkg::addr_t buffer_2,     // Length and endian flags
  output logic              ap_idle,
  output logic              ap_ready,
  output logic              ap_done,
  kernel_phase_if.ctrl      read_phase,
  kernel_phase_if.ctrl      write_phase
);

  // Longest burst the line buffer holds
  localparam kernel_pkg::len_t LEN_LIMIT = kernel_pkg::len_t'(`KERNEL_MAX_BEATS - 1);

  kernel_pkg::ctrl_state_t state;
  kernel_pkg::addr_t       src_addr;
  kernel_pkg::addr_t       dst_addr;
  kernel_pkg::len_t        beats_m1;
  kernel_pkg::len_t        len_req;
  logic                    endian_read;
  logic                    endian_write;
  logic                    start_run;

  // ap_start only counts while idle
  assign start_run = (state == kernel_pkg::IDLE) && ap_start;

  // Clamp the requested length to the buffer depth
  assign len_req = (buffer_2[`KERNEL_LEN_W-1:0] > LEN_LIMIT) ? LEN_LIMIT
                                                             : buffer_2[`KERNEL_LEN_W-1:0];

  // ----------------------------------------
  // Control chain FSM
  // ----------------------------------------
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      state             <= kernel_pkg::IDLE;
      ap_ready          <= 1'b0;
      read_phase.start  <= 1'b0;
      write_phase.start <= 1'b0;
    end else begin
      ap_ready          <= start_run;  // One pulse per accepted start
      read_phase.start  <= start_run;  // Read begins with the latch
      write_phase.start <= 1'b0;
      case (state)
        kernel_pkg::IDLE: begin
          if (ap_start) state <= kernel_pkg::READ;
        end
        kernel_pkg::READ: begin
          if (read_phase.done) begin
            state             <= kernel_pkg::WRITE;
            write_phase.start <= 1'b1;  // Buffer is full now
          end
        end
        kernel_pkg::WRITE: begin
          if (write_phase.done) state <= kernel_pkg::DONE;
        end
        kernel_pkg::DONE: begin
          if (ap_continue) state <= kernel_pkg::IDLE;  // Host acknowledged
        end
        default: state <= kernel_pkg::IDLE;
      endcase
    end
  end

  // Descriptor snapshot, later port changes are ignored
  always_ff @(posedge ap_clk) begin
    if (start_run) begin
      src_addr     <= buffer_0;
      dst_addr     <= buffer_1;
      beats_m1     <= len_req;
      endian_read  <= buffer_2[`KERNEL_LEN_W];
      endian_write <= buffer_2[`KERNEL_LEN_W+1];
    end
  end

  assign ap_idle = (state == kernel_pkg::IDLE);
  assign ap_done = (state == kernel_pkg::DONE);  // Held until ap_continue

  // Phase payloads, sampled by the engines with start
  assign read_phase.addr    = src_addr;
  assign read_phase.len     = beats_m1;
  assign read_phase.endian  = endian_read;
  assign write_phase.addr   = dst_addr;
  assign write_phase.len    = beats_m1;
  assign write_phase.endian = endian_write;

endmodule

`default_nettype wire

// File: src/kernel_if.sv
/* Kernel internal interfaces
   Phase request between control and engines, line buffer access */

`default_nettype none

// ----------------------------------------
// One phase request, control to engine
// ----------------------------------------
interface kernel_phase_if;
  logic              start;   // Single cycle request
  logic              done;    // Single cycle completion
  kernel_pkg::addr_t addr;    // Burst base address
  kernel_pkg::len_t  len;     // Beats minus one
  logic              endian;  // Swap bytes of each beat

  modport ctrl (output start, addr, len, endian, input done);
  modport engine (input start, addr, len, endian, output done);
endinterface

// ----------------------------------------
// Line buffer ports
// ----------------------------------------
interface kernel_buffer_if;
  logic                  wr_en;
  kernel_pkg::beat_idx_t wr_idx;
  kernel_pkg::data_t     wr_data;
  kernel_pkg::beat_idx_t rd_idx;
  kernel_pkg::data_t     rd_data;  // Combinational from rd_idx

  // Read engine side
  modport fill (output wr_en, wr_idx, wr_data);
  // Write engine side
  modport drain (output rd_idx, input rd_data);
  // Storage itself
  modport store (input wr_en, wr_idx, wr_data, rd_idx, output rd_data);
endinterface

`default_nettype wire

// File: src/kernel_line_buffer.sv
/* Line buffer, one burst of beats between the read and write engines */

`default_nettype none

`include "kernel_settings.svh"

module kernel_line_buffer (
  input  logic           ap_clk,
  kernel_buffer_if.store buf_store
);

  kernel_pkg::data_t mem [`KERNEL_MAX_BEATS];  // Payload only, no reset

  // Fill side
  always_ff @(posedge ap_clk) begin
    if (buf_store.wr_en) begin
      mem[buf_store.wr_idx] <= buf_store.wr_data;
    end
  end

  // Drain side, combinational read
  assign buf_store.rd_data = mem[buf_store.rd_idx];

endmodule

`default_nettype wire

// File: src/kernel_pkg.sv
/* Kernel package
   Width typedefs, control states and the beat byte swap */

`default_nettype none

`include "kernel_settings.svh"

package kernel_pkg;

  // Bytes per beat for the swap
  localparam int BEAT_BYTES = `KERNEL_DATA_W / 8;

  typedef logic [`KERNEL_DATA_W-1:0]            data_t;      // One beat
  typedef logic [`KERNEL_ADDR_W-1:0]            addr_t;      // Byte address
  typedef logic [`KERNEL_LEN_W-1:0]             len_t;       // Beats minus one
  typedef logic [$clog2(`KERNEL_MAX_BEATS)-1:0] beat_idx_t;  // Line buffer slot

  // ap_ctrl_chain sequencing
  typedef enum logic [1:0] {
    IDLE,   // Waiting for ap_start
    READ,   // Source burst in flight
    WRITE,  // Destination burst in flight
    DONE    // Holding ap_done for ap_continue
  } ctrl_state_t;

  // Reverse byte order of a full beat when swap is set
  function automatic data_t swap_beat(input data_t beat, input logic swap);
    data_t swapped;
    for (int b = 0; b < BEAT_BYTES; b++) begin
      swapped[8*b +: 8] = beat[8*(BEAT_BYTES-1-b) +: 8];
    end
    return swap ? swapped : beat;
  endfunction

endpackage

`default_nettype wire

// File: src/kernel_read_engine.sv
/* AXI4 read engine
   One burst from the source into the line buffer, optional byte swap */

`default_nettype none

module kernel_read_engine (
  input  logic              ap_clk,
  input  logic              areset,
  kernel_phase_if.engine    phase,
  kernel_buffer_if.fill     buf_fill,
  output logic              m_axi_arvalid,
  input  logic              m_axi_arready,
  output kernel_pkg::addr_t m_axi_araddr,
  output kernel_pkg::len_t  m_axi_arlen,
  input  logic              m_axi_rvalid,
  output logic              m_axi_rready,
  input  kernel_pkg::data_t m_axi_rdata,
  input  logic              m_axi_rlast
);

  logic                  endian_read;  // Latched with start
  logic                  beat_accept;
  kernel_pkg::beat_idx_t wr_idx;

  assign beat_accept = m_axi_rvalid & m_axi_rready;

  // ----------------------------------------
  // Address then data, one burst
  // ----------------------------------------
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      m_axi_arvalid <= 1'b0;
      m_axi_rready  <= 1'b0;
      phase.done    <= 1'b0;
    end else begin
      phase.done <= 1'b0;
      if (phase.start) begin
        m_axi_arvalid <= 1'b1;
      end else if (m_axi_arvalid && m_axi_arready) begin
        m_axi_arvalid <= 1'b0;
        m_axi_rready  <= 1'b1;  // Buffer always has room
      end
      if (beat_accept && m_axi_rlast) begin
        m_axi_rready <= 1'b0;
        phase.done   <= 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (phase.start) begin
      m_axi_araddr <= phase.addr;
      m_axi_arlen  <= phase.len;
      endian_read  <= phase.endian;
    end
  end

  // Read side ends on rlast, last flag not needed
  kernel_beat_counter u_beat_counter (
    .ap_clk  (ap_clk),
    .areset  (areset),
    .clear   (phase.start),
    .advance (beat_accept),
    .len     (m_axi_arlen),
    .idx     (wr_idx),
    .last    ()
  );

  assign buf_fill.wr_en   = beat_accept;
  assign buf_fill.wr_idx  = wr_idx;
  assign buf_fill.wr_data = kernel_pkg::swap_beat(m_axi_rdata, endian_read);

endmodule

`default_nettype wire

// File: src/kernel_reset_hold.sv
/* Reset stretcher, keeps the kernel in reset for a fixed hold after ap_rst_n */

`default_nettype none

`include "kernel_settings.svh"

module kernel_reset_hold (
  input  logic ap_clk,
  input  logic ap_rst_n,
  output logic areset_kernel  // Active high, registered
);

  localparam int CNT_W = $clog2(`KERNEL_RESET_HOLD + 1);

  logic [CNT_W-1:0] hold_cnt;  // Cycles left in the hold

  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      hold_cnt      <= CNT_W'(`KERNEL_RESET_HOLD - 1);  // Reload on every assertion
      areset_kernel <= 1'b1;
    end else begin
      if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      areset_kernel <= (hold_cnt != '0);  // Drops the cycle the count hits zero
    end
  end

endmodule

`default_nettype wire

// File: src/kernel_write_engine.sv
/* AXI4 write engine
   Drains the line buffer as one burst to the destination, optional byte swap */

`default_nettype none

module kernel_write_engine (
  input  logic              ap_clk,
  input  logic              areset,
  kernel_phase_if.engine    phase,
  kernel_buffer_if.drain    buf_drain,
  output logic              m_axi_awvalid,
  input  logic              m_axi_awready,
  output kernel_pkg::addr_t m_axi_awaddr,
  output kernel_pkg::len_t  m_axi_awlen,
  output logic              m_axi_wvalid,
  input  logic              m_axi_wready,
  output kernel_pkg::data_t m_axi_wdata,
  output logic              m_axi_wlast,
  input  logic              m_axi_bvalid,
  output logic              m_axi_bready
);

  logic                  endian_write;  // Latched with start
  logic                  beat_accept;
  logic                  beat_last;
  kernel_pkg::beat_idx_t rd_idx;

  assign beat_accept = m_axi_wvalid & m_axi_wready;

  // ----------------------------------------
  // Address, data, response
  // ----------------------------------------
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      m_axi_awvalid <= 1'b0;
      m_axi_wvalid  <= 1'b0;
      m_axi_bready  <= 1'b0;
      phase.done    <= 1'b0;
    end else begin
      phase.done <= 1'b0;
      if (phase.start) begin
        m_axi_awvalid <= 1'b1;
      end else if (m_axi_awvalid && m_axi_awready) begin
        m_axi_awvalid <= 1'b0;
        m_axi_wvalid  <= 1'b1;  // Data follows the address
      end
      if (beat_accept && m_axi_wlast) begin
        m_axi_wvalid <= 1'b0;
        m_axi_bready <= 1'b1;   // Wait for the response
      end
      if (m_axi_bvalid && m_axi_bready) begin
        m_axi_bready <= 1'b0;
        phase.done   <= 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (phase.start) begin
      m_axi_awaddr <= phase.addr;
      m_axi_awlen  <= phase.len;
      endian_write <= phase.endian;
    end
  end

  kernel_beat_counter u_beat_counter (
    .ap_clk  (ap_clk),
    .areset  (areset),
    .clear   (phase.start),
    .advance (beat_accept),
    .len     (m_axi_awlen),
    .idx     (rd_idx),
    .last    (beat_last)
  );

  // Payload follows the index, stable while wready is low
  assign buf_drain.rd_idx = rd_idx;
  assign m_axi_wdata      = kernel_pkg::swap_beat(buf_drain.rd_data, endian_write);
  assign m_axi_wlast      = m_axi_wvalid & beat_last;

endmodule

`default_nettype wire
